/* hdl/mipsConsts.svh */
// widths, register count and PC constants of the multicycle MIPS core, included by packages and RTL
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// ------------------------------
// datapath widths
// ------------------------------
`define WORD_W    32   // data and address
`define OPCODE_W  6
`define FUNCT_W   6
`define SHAMT_W   5    // also the shift range of the ALU
`define IMM_W     16

// ------------------------------
// controller widths
// ------------------------------
`define STATE_W   4    // 13 states
`define SEL_W     2    // mux selects and ALU op class

// register file
`define REG_CNT   32

// program counter
`define RESET_PC  32'h0000_0000
`define PC_STEP   4    // one word per instruction

`endif

/* hdl/isaPkg.sv */
// instruction-set types of the MIPS subset, shared by controller, datapath and testbench
package isaPkg;

`include "mipsConsts.svh"

   typedef logic [`WORD_W-1:0] word_t;                  // data and addresses
   typedef logic [$clog2(`REG_CNT)-1:0] regIdx_t;       // rs, rt, rd fields

   // instr[31:26], standard MIPS encodings
   typedef enum logic [`OPCODE_W-1:0]
   {
      OP_RTYPE = 6'b000000,
      OP_J     = 6'b000010,
      OP_BEQ   = 6'b000100,
      OP_BNE   = 6'b000101,
      OP_ADDI  = 6'b001000,
      OP_ANDI  = 6'b001100,
      OP_LW    = 6'b100011,
      OP_SW    = 6'b101011
   } opcode_e;

   // instr[5:0] of R-type
   typedef enum logic [`FUNCT_W-1:0]
   {
      F_SLL = 6'b000000,
      F_SRL = 6'b000010,
      F_ADD = 6'b100000,
      F_SUB = 6'b100010,
      F_OR  = 6'b100101
   } funct_e;

endpackage

/* hdl/ctrlPkg.sv */
// controller types of the multicycle MIPS core: FSM states, ALU op class and mux selects
package ctrlPkg;

`include "mipsConsts.svh"

   typedef enum logic [`STATE_W-1:0]
   {
      FETCH, DECODE,
      MEMADR, LWRD, LWWR, SWWR,          // memory path
      RTYPEEX, ALUWR, ADDIEX, ANDIEX,    // ALU path, shared write back
      BEQEX, BNEEX, JEX                  // control flow
   } ctrlState_e;

   // OP_FUNCT hands the choice to the funct field
   typedef enum logic [`SEL_W-1:0] {OP_ADD, OP_SUB, OP_AND, OP_FUNCT} aluOp_e;

   // ------------------------------
   // mux selects
   // ------------------------------
   typedef enum logic [`SEL_W-1:0] {A_PC, A_REG, A_SHAMT} srcA_e;

   typedef enum logic [`SEL_W-1:0] {B_REG, B_FOUR, B_SIGNIMM, B_BRANCHOFS} srcB_e;

   typedef enum logic [`SEL_W-1:0] {PC_ALU, PC_ALUOUT, PC_JUMP} pcSrc_e;

   typedef enum logic {DST_RT, DST_RD} regDst_e;

endpackage

/* hdl/ctrlIf.sv */
// control levels from the FSM to the datapath, with opcode and zero flag coming back
`timescale 1ns/1ns

interface ctrlIf;
   import isaPkg::*;
   import ctrlPkg::*;

   logic    irWrite;
   logic    pcEn;
   logic    iOrD;        // memory address from ALU-out instead of PC
   srcA_e   aluSrcA;
   srcB_e   aluSrcB;
   aluOp_e  aluOp;
   pcSrc_e  pcSource;
   regDst_e regDst;
   logic    memToReg;    // write back from MDR
   logic    regWrite;

   opcode_e opcode;      // from the instruction register
   logic    zero;

   modport ctrl (output irWrite, pcEn, iOrD, aluSrcA, aluSrcB, aluOp, pcSource,
                 regDst, memToReg, regWrite,
                 input  opcode, zero);

   modport path (input  irWrite, pcEn, iOrD, aluSrcA, aluSrcB, aluOp, pcSource,
                 regDst, memToReg, regWrite,
                 output opcode, zero);

endinterface

/* hdl/mainControl.sv */
// multicycle FSM of the MIPS core, decodes state and opcode into control levels and PC enable
`timescale 1ns/1ns

module mainControl
(
   input logic clk,
   input logic reset,
   ctrlIf.ctrl ctrl,
   output logic memRead,
   output logic memWrite
);
   import isaPkg::*;
   import ctrlPkg::*;

   ctrlState_e state;
   ctrlState_e nextState;
   logic       pcWrite;     // unconditional
   logic       branchEq;
   logic       branchNe;

   always_ff @(posedge clk)
   begin
      if (reset)
         state <= FETCH;
      else
         state <= nextState;
   end

   // ------------------------------
   // next state
   // ------------------------------
   always_comb
   begin
      nextState = FETCH;
      case (state)
         FETCH:   nextState = DECODE;
         DECODE:
         begin
            case (ctrl.opcode)
               OP_LW, OP_SW: nextState = MEMADR;
               OP_RTYPE:     nextState = RTYPEEX;
               OP_ADDI:      nextState = ADDIEX;
               OP_ANDI:      nextState = ANDIEX;
               OP_BEQ:       nextState = BEQEX;
               OP_BNE:       nextState = BNEEX;
               OP_J:         nextState = JEX;
               default:      nextState = FETCH;   // unsupported opcode skipped
            endcase
         end
         MEMADR:  nextState = (ctrl.opcode == OP_LW) ? LWRD : SWWR;
         LWRD:    nextState = LWWR;
         RTYPEEX, ADDIEX, ANDIEX: nextState = ALUWR;
         default: nextState = FETCH;   // LWWR, SWWR, ALUWR and branches end here
      endcase
   end

   // ------------------------------
   // output decode
   // ------------------------------
   always_comb
   begin
      memRead       = 1'b0;
      memWrite      = 1'b0;
      ctrl.irWrite  = 1'b0;
      ctrl.iOrD     = 1'b0;
      ctrl.aluSrcA  = A_PC;
      ctrl.aluSrcB  = B_REG;
      ctrl.aluOp    = OP_ADD;
      ctrl.pcSource = PC_ALU;
      ctrl.regDst   = DST_RT;
      ctrl.memToReg = 1'b0;
      ctrl.regWrite = 1'b0;
      pcWrite       = 1'b0;
      branchEq      = 1'b0;
      branchNe      = 1'b0;
      case (state)
         FETCH:
         begin
            memRead      = 1'b1;
            ctrl.irWrite = 1'b1;
            ctrl.aluSrcB = B_FOUR;   // pc + 4 straight into the PC
            pcWrite      = 1'b1;
         end
         DECODE:  ctrl.aluSrcB = B_BRANCHOFS;   // branch target lands in ALU-out
         MEMADR:
         begin
            ctrl.aluSrcA = A_REG;
            ctrl.aluSrcB = B_SIGNIMM;
         end
         LWRD:
         begin
            memRead   = 1'b1;
            ctrl.iOrD = 1'b1;
         end
         LWWR:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.memToReg = 1'b1;
         end
         SWWR:
         begin
            memWrite  = 1'b1;
            ctrl.iOrD = 1'b1;
         end
         RTYPEEX:
         begin
            ctrl.aluSrcA = A_SHAMT;   // rs + shamt, one of them is zero
            ctrl.aluOp   = OP_FUNCT;
         end
         ADDIEX, ANDIEX:
         begin
            ctrl.aluSrcA = A_REG;
            ctrl.aluSrcB = B_SIGNIMM;
            ctrl.aluOp   = (state == ANDIEX) ? OP_AND : OP_ADD;
         end
         ALUWR:
         begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = (ctrl.opcode == OP_RTYPE) ? DST_RD : DST_RT;
         end
         BEQEX, BNEEX:
         begin
            ctrl.aluSrcA  = A_REG;
            ctrl.aluOp    = OP_SUB;      // compare rs with rt
            ctrl.pcSource = PC_ALUOUT;
            branchEq      = (state == BEQEX);
            branchNe      = (state == BNEEX);
         end
         JEX:
         begin
            ctrl.pcSource = PC_JUMP;
            pcWrite       = 1'b1;
         end
         default: ;
      endcase
   end

   assign ctrl.pcEn = pcWrite | (branchEq & ctrl.zero) | (branchNe & ~ctrl.zero);

   // single memory port
   memPortExclusive: assert property (@(posedge clk) disable iff (reset)
      !(memRead && memWrite))
      else $error("memRead and memWrite high together in state %s", state.name());

endmodule

/* hdl/regFile.sv */
// 32-entry register file with two combinational reads and one clocked write, r0 reads zero
`timescale 1ns/1ns

module regFile
(
   input logic clk,
   input logic regWrite,
   input isaPkg::regIdx_t readAddr1,
   input isaPkg::regIdx_t readAddr2,
   input isaPkg::regIdx_t writeAddr,
   input isaPkg::word_t writeValue,
   output isaPkg::word_t readValue1,
   output isaPkg::word_t readValue2
);
   import isaPkg::*;

`include "mipsConsts.svh"

   word_t regs [`REG_CNT];

   always_ff @(posedge clk)
   begin
      if (regWrite)
         regs[writeAddr] <= writeValue;   // r0 may be written, never read
   end

   // register 0 hardwired to zero
   assign readValue1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
   assign readValue2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

/* hdl/aluUnit.sv */
// ALU of the MIPS core, resolves the operation from the controller's op class and the funct field
`timescale 1ns/1ns

module aluUnit
(
   input isaPkg::word_t srcA,
   input isaPkg::word_t srcB,
   input ctrlPkg::aluOp_e aluOp,
   input isaPkg::funct_e funct,
   output isaPkg::word_t result,
   output logic zero
);
   import isaPkg::*;
   import ctrlPkg::*;

`include "mipsConsts.svh"

   logic [`SHAMT_W-1:0] shift;

   assign shift = srcA[`SHAMT_W-1:0];

   always_comb
   begin
      case (aluOp)
         OP_ADD: result = srcA + srcB;
         OP_SUB: result = srcA - srcB;
         OP_AND: result = srcA & srcB;
         OP_FUNCT:
         begin
            case (funct)
               F_ADD:   result = srcA + srcB;
               F_SUB:   result = srcA - srcB;
               F_OR:    result = srcA | srcB;
               F_SLL:   result = srcB << shift;   // rt moved by shamt
               F_SRL:   result = srcB >> shift;
               default: result = '0;
            endcase
         end
         default: result = '0;
      endcase
   end

   assign zero = (result == '0);   // branch compare

   // only flag funct when the FSM actually uses it
   always_comb
   begin
      if (aluOp == OP_FUNCT)
      begin
         unsupportedFunct: assert final (funct inside {F_ADD, F_SUB, F_OR, F_SLL, F_SRL})
            else $error("R-type funct %b not supported", funct);
      end
   end

endmodule

/* hdl/dataPath.sv */
// datapath of the multicycle MIPS core: PC, IR, MDR, A/B/ALU-out registers, muxes, regs and ALU
`timescale 1ns/1ns

module dataPath
(
   input logic clk,
   input logic reset,
   ctrlIf.path ctrl,
   input isaPkg::word_t memData,
   output isaPkg::word_t adr,
   output isaPkg::word_t writeData
);
   import isaPkg::*;
   import ctrlPkg::*;

`include "mipsConsts.svh"

   word_t   pc, nextPc, instr, memDataReg;
   word_t   regA, regB, aluOut, aluResult;
   word_t   srcA, srcB, signImm, zeroImm, jumpTarget;
   word_t   readValue1, readValue2, writeValue;
   regIdx_t writeAddr;
   funct_e  funct;
   logic    aluZero;

   // ------------------------------
   // instruction fields
   // ------------------------------
   regIdx_t             rs, rt, rd;
   logic [`SHAMT_W-1:0] shamt;
   logic [`IMM_W-1:0]   imm;

   assign rs    = instr[25:21];
   assign rt    = instr[20:16];
   assign rd    = instr[15:11];
   assign shamt = instr[10:6];
   assign imm   = instr[`IMM_W-1:0];
   assign funct = funct_e'(instr[`FUNCT_W-1:0]);

   assign ctrl.opcode = opcode_e'(instr[`WORD_W-1 -: `OPCODE_W]);
   assign ctrl.zero   = aluZero;

   assign signImm    = {{(`WORD_W - `IMM_W){imm[`IMM_W-1]}}, imm};
   assign zeroImm    = {{(`WORD_W - `IMM_W){1'b0}}, imm};   // logical immediate of ANDI
   assign jumpTarget = {pc[`WORD_W-1 -: 4], instr[`WORD_W-7:0], 2'b00};   // pc already + 4

   always_ff @(posedge clk)
   begin
      if (reset)
         pc <= `RESET_PC;
      else if (ctrl.pcEn)
         pc <= nextPc;
   end

   always_ff @(posedge clk)
   begin
      if (ctrl.irWrite)
         instr <= memData;
   end

   // loaded every cycle, the FSM only samples them where valid
   always_ff @(posedge clk)
   begin
      memDataReg <= memData;
      regA       <= readValue1;
      regB       <= readValue2;
      aluOut     <= aluResult;
   end

   // ------------------------------
   // multiplexers
   // ------------------------------
   always_comb
   begin
      case (ctrl.aluSrcA)
         A_REG:   srcA = regA;
         A_SHAMT: srcA = regA + word_t'(shamt);   // rs is zero for shifts
         default: srcA = pc;
      endcase
      case (ctrl.aluSrcB)
         B_FOUR:      srcB = word_t'(`PC_STEP);
         B_SIGNIMM:   srcB = (ctrl.opcode == OP_ANDI) ? zeroImm : signImm;
         B_BRANCHOFS: srcB = signImm << 2;   // word offset
         default:     srcB = regB;
      endcase
      case (ctrl.pcSource)
         PC_ALUOUT: nextPc = aluOut;
         PC_JUMP:   nextPc = jumpTarget;
         default:   nextPc = aluResult;
      endcase
   end

   assign adr        = ctrl.iOrD ? aluOut : pc;
   assign writeData  = regB;   // rt value for SW
   assign writeAddr  = (ctrl.regDst == DST_RD) ? rd : rt;
   assign writeValue = ctrl.memToReg ? memDataReg : aluOut;

   regFile regs0
   (
      .clk(clk),
      .regWrite(ctrl.regWrite),
      .readAddr1(rs),
      .readAddr2(rt),
      .writeAddr(writeAddr),
      .writeValue(writeValue),
      .readValue1(readValue1),
      .readValue2(readValue2)
   );

   aluUnit alu0
   (
      .srcA(srcA),
      .srcB(srcB),
      .aluOp(ctrl.aluOp),
      .funct(funct),
      .result(aluResult),
      .zero(aluZero)
   );

   // branch offsets and jump targets keep word alignment
   pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
      else $error("PC %h not word aligned", pc);

endmodule

/* hdl/mipsCore.sv */
// top level of the multicycle MIPS core, joins the FSM and the datapath to one memory port
`timescale 1ns/1ns

module mipsCore
(
   input logic clk,
   input logic reset,
   input isaPkg::word_t memData,     // combinational read at adr
   output logic memRead,
   output logic memWrite,
   output isaPkg::word_t adr,
   output isaPkg::word_t writeData
);

   ctrlIf ctrlBus ();

   mainControl control0
   (
      .clk(clk),
      .reset(reset),
      .ctrl(ctrlBus.ctrl),
      .memRead(memRead),
      .memWrite(memWrite)
   );

   dataPath path0
   (
      .clk(clk),
      .reset(reset),
      .ctrl(ctrlBus.path),
      .memData(memData),
      .adr(adr),
      .writeData(writeData)
   );

endmodule

/* testbench/refModel.svh */
// instruction-level model of the MIPS subset, included by tbMips to predict each program's stores
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

// runs refMem from the reset PC up to the marker store, returns instructions executed
function automatic int runReference(int maxInstr);
   word_t      regs [`REG_CNT];
   word_t      pc, instr, rsVal, rtVal, immSext, immZext, memAdr;
   logic [5:0] op, fn;
   logic [4:0] rs, rt, rd, shamt;
   int         count;
   logic       done;

   pc = `RESET_PC;
   count = 0;
   done = 1'b0;
   foreach (regs[i])
      regs[i] = '0;
   while (!done && count < maxInstr)
   begin
      instr   = refMem[pc[9:2]];
      op      = instr[31:26];
      rs      = instr[25:21];
      rt      = instr[20:16];
      rd      = instr[15:11];
      shamt   = instr[10:6];
      fn      = instr[5:0];
      rsVal   = regs[rs];
      rtVal   = regs[rt];
      immSext = {{16{instr[15]}}, instr[15:0]};
      immZext = {16'h0000, instr[15:0]};   // logical immediate
      memAdr  = rsVal + immSext;
      pc      = pc + `PC_STEP;
      count++;
      case (op)
         OP_RTYPE:
         begin
            case (fn)
               F_ADD:   regs[rd] = rsVal + rtVal;
               F_SUB:   regs[rd] = rsVal - rtVal;
               F_OR:    regs[rd] = rsVal | rtVal;
               F_SLL:   regs[rd] = rtVal << shamt;
               F_SRL:   regs[rd] = rtVal >> shamt;
               default: regs[rd] = '0;
            endcase
         end
         OP_ADDI: regs[rt] = rsVal + immSext;
         OP_ANDI: regs[rt] = rsVal & immZext;
         OP_LW:   regs[rt] = refMem[memAdr[9:2]];
         OP_SW:
         begin
            refMem[memAdr[9:2]] = rtVal;
            expAdr.push_back(memAdr);
            expData.push_back(rtVal);
            done = (memAdr == MARKER_ADR);
         end
         OP_BEQ:  if (rsVal == rtVal) pc = pc + (immSext << 2);
         OP_BNE:  if (rsVal != rtVal) pc = pc + (immSext << 2);
         OP_J:    pc = {pc[31:28], instr[25:0], 2'b00};   // upper bits of pc + 4
         default: ;
      endcase
      regs[0] = '0;   // r0 hardwired
   end
   return count;
endfunction

`endif

/* testbench/tbMips.sv */
// testbench of the multicycle MIPS core: memory model, test programs, reference compare, report
`timescale 1ns/1ns

module tbMips;
   import isaPkg::*;

`include "mipsConsts.svh"

   localparam int    CLK_PERIOD    = 20;
   localparam int    RESET_CYCLES  = 10;
   localparam int    MEM_WORDS     = 256;
   localparam int    MARGIN_CYCLES = 40;
   localparam word_t MARKER_ADR    = 32'h0000_03FC;   // last word, ends every program

   logic   clk, reset, memRead, memWrite;
   word_t  memData, adr, writeData;

   word_t  mem [MEM_WORDS];
   word_t  refMem [MEM_WORDS];
   word_t  expAdr [$];
   word_t  expData [$];
   int     progLen;
   logic   collecting, markerSeen, wrPending;
   word_t  wrAdr, wrData;
   int     testErrors, storeCount, testsPassed, testsFailed;
   longint budget, cycles;

`include "refModel.svh"

   mipsCore dut0
   (
      .clk(clk),
      .reset(reset),
      .memData(memData),
      .memRead(memRead),
      .memWrite(memWrite),
      .adr(adr),
      .writeData(writeData)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   task automatic checkValue(string name, word_t got, word_t exp);
      if (got !== exp)
      begin
         $display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
         testErrors++;
      end
   endtask

   // ------------------------------
   // memory model and store compare
   // ------------------------------
   always @(negedge clk)
   begin
      memData   <= mem[adr[9:2]];   // combinational read, settled by now
      wrPending <= (memWrite === 1'b1);
      wrAdr     <= adr;
      wrData    <= writeData;
      if (collecting && memWrite === 1'b1)
      begin
         storeCount++;
         if (expAdr.size() == 0)
         begin
            $display("store to %h at %0t ns was not expected", adr, $time);
            testErrors++;
         end
         else
         begin
            checkValue("adr", adr, expAdr.pop_front());
            checkValue("writeData", writeData, expData.pop_front());
         end
         if (adr == MARKER_ADR)
            markerSeen = 1'b1;
      end
   end

   always @(posedge clk)
   begin
      if (wrPending)
         mem[wrAdr[9:2]] <= wrData;
   end

   // ------------------------------
   // program building
   // ------------------------------
   function automatic word_t rtypeWord(funct_e fn, int rs, int rt, int rd, int shamt);
      return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], fn};
   endfunction

   function automatic word_t immWord(opcode_e op, int rs, int rt, logic [15:0] imm);
      return {op, rs[4:0], rt[4:0], imm};
   endfunction

   function automatic word_t jumpWord(int wordIdx);
      return {OP_J, wordIdx[25:0]};
   endfunction

   task automatic clearMemory();
      foreach (mem[i])
         mem[i] = {i[7:0], ~i[7:0], 8'h5a, i[7:0]};   // distinct per word
      progLen = 0;
   endtask

   task automatic appendInstr(word_t w);
      mem[progLen] = w;
      progLen++;
   endtask

   task automatic endProgram();
      appendInstr(immWord(OP_SW, 0, 0, MARKER_ADR[15:0]));
      appendInstr(32'h0000_0000);   // nop, fetched before reset returns
   endtask

   task automatic buildRtypeProgram();
      logic [4:0] sh;
      sh = 5'($urandom);
      clearMemory();
      appendInstr(immWord(OP_ADDI, 0, 1, 16'($urandom)));
      appendInstr(immWord(OP_ADDI, 0, 2, 16'($urandom)));
      appendInstr(rtypeWord(F_ADD, 1, 2, 3, 0));
      appendInstr(rtypeWord(F_SUB, 1, 2, 4, 0));
      appendInstr(rtypeWord(F_OR, 1, 2, 5, 0));
      appendInstr(rtypeWord(F_SLL, 0, 1, 6, sh));
      appendInstr(rtypeWord(F_SRL, 0, 1, 7, sh));
      appendInstr(rtypeWord(F_ADD, 1, 2, 0, 0));   // write to r0
      for (int r = 0; r < 8; r++)
         appendInstr(immWord(OP_SW, 0, r, 16'(512 + 4 * r)));
      endProgram();
   endtask

   task automatic buildImmProgram();
      logic [15:0] negImm;
      negImm = 16'($urandom) | 16'h8000;
      clearMemory();
      appendInstr(immWord(OP_ADDI, 0, 1, 16'($urandom)));
      appendInstr(immWord(OP_ADDI, 1, 2, negImm));   // sign extension
      appendInstr(immWord(OP_ANDI, 2, 3, 16'($urandom)));
      appendInstr(immWord(OP_ANDI, 1, 4, negImm));   // zero extension
      appendInstr(immWord(OP_ADDI, 0, 5, negImm));
      for (int r = 1; r < 6; r++)
         appendInstr(immWord(OP_SW, 0, r, 16'(512 + 4 * r)));
      endProgram();
   endtask

   task automatic buildMemProgram();
      int idx;
      clearMemory();
      for (int k = 0; k < 3; k++)
      begin
         idx = 128 + k * 40 + $urandom_range(38);   // three separate areas
         appendInstr(immWord(OP_ADDI, 0, 1, 16'(idx * 4)));
         appendInstr(immWord(OP_ADDI, 0, 2, 16'($urandom)));
         appendInstr(immWord(OP_SW, 1, 2, 16'h0000));
         appendInstr(immWord(OP_LW, 1, 3, 16'h0000));
         appendInstr(rtypeWord(F_ADD, 3, 3, 4, 0));
         appendInstr(immWord(OP_SW, 1, 4, 16'h0000));
      end
      endProgram();
   endtask

   task automatic buildBranchProgram();
      clearMemory();
      appendInstr(immWord(OP_ADDI, 0, 1, 16'd5));
      appendInstr(immWord(OP_ADDI, 0, 2, 16'd5));
      appendInstr(immWord(OP_ADDI, 0, 3, 16'd7));
      appendInstr(immWord(OP_BEQ, 1, 2, 16'd1));   // taken
      appendInstr(immWord(OP_SW, 0, 1, 16'h0200));
      appendInstr(immWord(OP_SW, 0, 1, 16'h0204));
      appendInstr(immWord(OP_BEQ, 1, 3, 16'd1));   // not taken
      appendInstr(immWord(OP_SW, 0, 3, 16'h0208));
      appendInstr(immWord(OP_SW, 0, 3, 16'h020c));
      appendInstr(immWord(OP_BNE, 1, 3, 16'd1));   // taken
      appendInstr(immWord(OP_SW, 0, 1, 16'h0210));
      appendInstr(immWord(OP_SW, 0, 1, 16'h0214));
      appendInstr(immWord(OP_BNE, 1, 2, 16'd1));   // not taken
      appendInstr(immWord(OP_SW, 0, 2, 16'h0218));
      appendInstr(immWord(OP_SW, 0, 2, 16'h021c));
      appendInstr(jumpWord(progLen + 3));   // over two stores
      appendInstr(immWord(OP_SW, 0, 3, 16'h0220));
      appendInstr(immWord(OP_SW, 0, 3, 16'h0224));
      appendInstr(immWord(OP_SW, 0, 3, 16'h0228));
      endProgram();
   endtask

   // ------------------------------
   // test sequencing
   // ------------------------------
   task automatic applyReset();
      repeat (RESET_CYCLES)
      begin
         @(negedge clk);
         reset = 1'b1;
         checkValue("memWrite", word_t'(memWrite), '0);
      end
      reset = 1'b0;
      checkValue("memRead", word_t'(memRead), word_t'(1));   // FETCH right after reset
      checkValue("adr", adr, `RESET_PC);
   endtask

   task automatic runTest(string name);
      int instrCount;
      refMem = mem;
      expAdr.delete();
      expData.delete();
      instrCount = runReference(1000);
      budget += instrCount * 5 + RESET_CYCLES + MARGIN_CYCLES;
      testErrors = 0;
      storeCount = 0;
      markerSeen = 1'b0;
      applyReset();
      collecting = 1'b1;
      wait (markerSeen);
      @(negedge clk);
      collecting = 1'b0;
      reset = 1'b1;
      if (expAdr.size() != 0)
      begin
         $display("%0d expected stores never happened", expAdr.size());
         testErrors++;
      end
      if (testErrors == 0)
      begin
         testsPassed++;
         $display("test %-7s ok, %0d instructions, %0d stores", name, instrCount, storeCount);
      end
      else
      begin
         testsFailed++;
         $display("test %-7s failed with %0d errors", name, testErrors);
      end
   endtask

   // watchdog, budget grows with each test's instruction count
   initial
   begin
      cycles = 0;
      while (cycles <= budget)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("run timed out after %0d cycles without reaching the marker store", cycles);
      $display("Regression failed");
      $finish;
   end

   initial
   begin
      void'($urandom(32'he3d2_73bc));
      reset       = 1'b1;
      memData     = '0;
      collecting  = 1'b0;
      markerSeen  = 1'b0;
      wrPending   = 1'b0;
      testsPassed = 0;
      testsFailed = 0;
      budget      = 0;

      clearMemory();
      endProgram();   // marker store only
      runTest("reset");
      buildRtypeProgram();
      runTest("rtype");
      buildImmProgram();
      runTest("imm");
      buildMemProgram();
      runTest("lwsw");
      buildBranchProgram();
      runTest("branch");

      $display("tests passed %0d failed %0d", testsPassed, testsFailed);
      if (testsFailed == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

/* flist.f */
+incdir+hdl
+incdir+testbench
hdl/isaPkg.sv
hdl/ctrlPkg.sv
hdl/ctrlIf.sv
hdl/mainControl.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/dataPath.sv
hdl/mipsCore.sv
testbench/tbMips.sv
